//--- project.f
+incdir+tests
common/ice51_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/code_loader.sv
verilog/ice51_serial_top.sv
tests/tb_ice51_serial.sv

//--- tests/tb_serial_tasks.svh
`ifndef TB_SERIAL_TASKS_SVH
`define TB_SERIAL_TASKS_SVH

//////////////////////////////////////////////////
// random bytes

function automatic logic [31:0] xorshift(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

//////////////////////////////////////////////////
// serial line driver called just after a rising edge

task automatic drive_rx_frame(input logic [7:0] b, input logic want_write);
   logic [9:0] bits;
   int         k;
   bits = {1'b1, b, 1'b0}; // start goes out first and LSB next
   wr_window <= want_write;
   last_exp  <= want_write && (rx_count == CODE_BYTES - 1);
   exp_data  <= b;
   exp_addr  <= 10'(rx_count);
   for (k = 0; k < 10; k++) begin
      i_uart_rx <= bits[k];
      repeat (BIT_CYCLES) @(posedge i_clk);
   end
   if (want_write) begin
      assert (!wr_window) else begin
         $display("no code write seen for received byte %02h by %0d ns", b, $time);
         error_count++;
      end
      rx_count++;
   end
endtask

//////////////////////////////////////////////////
// transmit one byte and sample the line at bit centers

task automatic send_tx_byte(input logic [7:0] b);
   int k;
   tx_exp_q.push_back(1'b0);
   for (k = 7; k >= 0; k--) tx_exp_q.push_back(b[k]); // MSB first
   tx_exp_q.push_back(1'b1);
   @(posedge i_clk);
   i_tx_start <= 1'b1;
   i_tx_data  <= b;
   @(posedge i_clk);
   i_tx_start <= 1'b0;
   busy_exp   <= 1'b1;
   repeat (HALF_CYCLES - 1) @(posedge i_clk);
   for (k = 0; k < 10; k++) begin
      tx_bit_exp <= tx_exp_q.pop_front();
      tx_check   <= 1'b1;
      @(posedge i_clk);
      tx_check <= 1'b0;
      if (k < 9) repeat (BIT_CYCLES - 1) @(posedge i_clk);
   end
   repeat (BIT_CYCLES - HALF_CYCLES) @(posedge i_clk); // end of stop bit
   busy_exp <= 1'b0;
endtask

`endif

//--- tests/tb_ice51_serial.sv
`default_nettype none

module tb_ice51_serial;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BIT_CYCLES     = 105;
   localparam int HALF_CYCLES    = 52;
   localparam int CODE_BYTES     = 512;
   localparam int TIMEOUT_CYCLES = 600000; // (CODE_BYTES + 8) frames of 1050 plus margin

   logic       i_clk;
   logic       i_nrst;
   logic       i_uart_rx;
   logic       i_tx_start;
   logic [7:0] i_tx_data;
   logic       o_uart_tx;
   logic       o_tx_busy;
   logic       o_code_wr;
   logic [9:0] o_code_addr;
   logic [7:0] o_code_data;
   logic       o_load_done;

   logic       idle_phase;
   logic       wr_window;              // one write allowed in this frame
   logic       last_exp;               // frame carries the final code byte
   logic       done_exp;
   logic [7:0] exp_data;
   logic [9:0] exp_addr;
   logic       busy_exp;
   logic       tx_check;
   logic       tx_bit_exp;
   logic       tx_exp_q[$];            // expected line bits from start to stop
   logic [31:0] rng;
   logic [7:0] rx_byte;
   int         rx_count;
   int         error_count;
   int         failed_tests;
   int         test_base;
   int         cycles;

   ice51_serial_top ice51_serial_top_i (.*);

   always #50 i_clk = ~i_clk;

   //////////////////////////////////////////////////
   // checks

   a_idle_line: assert property (@(posedge i_clk) disable iff (!i_nrst)
      idle_phase |-> o_uart_tx) else value_error("o_uart_tx", 1, $sampled(o_uart_tx));
   a_wr_in_window: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |-> wr_window) else value_error("o_code_wr", 0, 1);
   a_wr_data: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |-> o_code_data == exp_data)
      else value_error("o_code_data", $sampled(exp_data), $sampled(o_code_data));
   a_wr_addr: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |-> o_code_addr == exp_addr)
      else value_error("o_code_addr", $sampled(exp_addr), $sampled(o_code_addr));
   a_done_on_last: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (o_code_wr && last_exp) |-> o_load_done) else value_error("o_load_done", 1, 0);
   a_done_level: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !(o_code_wr && last_exp) |-> o_load_done == done_exp)
      else value_error("o_load_done", $sampled(done_exp), $sampled(o_load_done));
   a_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_tx_busy == busy_exp)
      else value_error("o_tx_busy", $sampled(busy_exp), $sampled(o_tx_busy));
   a_tx_bit: assert property (@(posedge i_clk) disable iff (!i_nrst)
      tx_check |-> o_uart_tx == tx_bit_exp)
      else value_error("o_uart_tx", $sampled(tx_bit_exp), $sampled(o_uart_tx));

   // window closes on the write and load done follows the final byte
   always @(posedge i_clk) begin
      if (o_code_wr) begin
         wr_window <= 1'b0;
         if (last_exp) done_exp <= 1'b1;
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("run timed out after %0d cycles", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic value_error(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
      error_count++;
   endtask

   task automatic report_test(input string name, input int base);
      if (error_count == base) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: failed with %0d errors", name, error_count - base);
         failed_tests++;
      end
   endtask

   //////////////////////////////////////////////////
   // stimulus

   initial begin
      i_clk        = 1'b0;
      i_nrst       = 1'b0;
      i_uart_rx    = 1'b1;
      i_tx_start   = 1'b0;
      i_tx_data    = '0;
      idle_phase   = 1'b0;
      wr_window    = 1'b0;
      last_exp     = 1'b0;
      done_exp     = 1'b0;
      exp_data     = '0;
      exp_addr     = '0;
      busy_exp     = 1'b0;
      tx_check     = 1'b0;
      tx_bit_exp   = 1'b1;
      rng          = 32'h2c73;
      rx_count     = 0;
      error_count  = 0;
      failed_tests = 0;
      cycles       = 0;
      repeat (10) @(posedge i_clk);
      i_nrst     <= 1'b1;
      idle_phase <= 1'b1;
      test_base = error_count;
      repeat (200) @(posedge i_clk); // quiet outputs before any stimulus
      idle_phase <= 1'b0;
      report_test("reset idle", test_base);

      test_base = error_count;
      repeat (3) begin
         rng = xorshift(rng);
         send_tx_byte(rng[7:0]);
      end
      report_test("transmit", test_base);

      test_base = error_count;
      rng = xorshift(rng);
      rx_byte = rng[7:0];
      rng = xorshift(rng);
      fork
         drive_rx_frame(rx_byte, 1'b1);
         send_tx_byte(rng[15:8]);
      join
      report_test("receive during transmit", test_base);

      test_base = error_count;
      while (rx_count < CODE_BYTES) begin
         rng = xorshift(rng);
         drive_rx_frame(rng[7:0], 1'b1);
      end
      report_test("code load", test_base);

      test_base = error_count;
      repeat (2) begin
         rng = xorshift(rng);
         drive_rx_frame(rng[7:0], 1'b0); // loader full so no write
      end
      report_test("after load done", test_base);

      $display("5 tests, %0d failed, %0d errors", failed_tests, error_count);
      if (error_count == 0) $display("PASS: all tests");
      else $display("FAIL: see errors above");
      $finish;
   end

   `include "tb_serial_tasks.svh"

endmodule

`default_nettype wire

//--- verilog/ice51_serial_top.sv
`default_nettype none

module ice51_serial_top (
   input  logic                              i_clk,
   input  logic                              i_nrst,
   input  logic                              i_uart_rx,
   input  logic                              i_tx_start,
   input  ice51_pkg::byte_t                  i_tx_data,
   output logic                              o_uart_tx,
   output logic                              o_tx_busy,
   output logic                              o_code_wr,
   output logic [ice51_pkg::CODE_ADDR_W-1:0] o_code_addr,
   output ice51_pkg::byte_t                  o_code_data,
   output logic                              o_load_done
);

   logic             rx_done;
   ice51_pkg::byte_t rx_data;

   //////////////////////////////////////////////////
   // receive path

   uart_rx uart_rx_i (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_rx   (i_uart_rx),
      .o_done (rx_done),
      .o_data (rx_data)
   );

   code_loader code_loader_i (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_byte_done (rx_done),
      .o_code_wr   (o_code_wr),
      .o_code_addr (o_code_addr),
      .o_load_done (o_load_done)
   );

   assign o_code_data = rx_data; // valid while o_code_wr is high

   //////////////////////////////////////////////////
   // transmit path

   uart_tx uart_tx_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (i_tx_start),
      .i_data  (i_tx_data),
      .o_tx    (o_uart_tx),
      .o_busy  (o_tx_busy)
   );

endmodule

`default_nettype wire

//--- verilog/code_loader.sv
`default_nettype none

module code_loader (
   input  logic                              i_clk,
   input  logic                              i_nrst,
   input  logic                              i_byte_done,
   output logic                              o_code_wr,
   output logic [ice51_pkg::CODE_ADDR_W-1:0] o_code_addr,
   output logic                              o_load_done
);

   logic [ice51_pkg::CODE_ADDR_W-2:0] byte_count;
   logic                              load_done_q;
   logic                              wrap;

   //////////////////////////////////////////////////
   // write strobe and byte count

   // gated by the latched level so the last byte still gets written
   assign o_code_wr = i_byte_done & ~load_done_q;
   assign wrap      = o_code_wr & (byte_count == ice51_pkg::CODE_BYTES - 1);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)         byte_count <= '0;
      else if (o_code_wr)  byte_count <= byte_count + 1'b1; // wraps to 0 on the last byte
   end

   assign o_code_addr = {1'b0, byte_count};

   //////////////////////////////////////////////////
   // load done

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)    load_done_q <= 1'b0;
      else if (wrap)  load_done_q <= 1'b1;
   end

   assign o_load_done = wrap | load_done_q; // high from the final write on

   //////////////////////////////////////////////////
   // checks

   a_no_write_after_done: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      $past(o_load_done) |-> !o_code_wr
   ) else $error("code write after load done");

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`default_nettype none

module uart_tx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_start,
   input  ice51_pkg::byte_t i_data,
   output logic             o_tx,
   output logic             o_busy
);

   localparam int BIT_CNT_W = $clog2(ice51_pkg::TX_FINAL_COUNT + 1);

   ice51_pkg::tx_state_t              state;
   ice51_pkg::tx_state_t              state_next;
   logic [ice51_pkg::SAMPLE_W-1:0]    sample_count;
   logic [BIT_CNT_W-1:0]              bit_count;
   logic [BIT_CNT_W-1:0]              bit_count_inc;
   ice51_pkg::byte_t                  shift;
   logic                              in_idle;
   logic                              in_start;
   logic                              in_send;
   logic                              load;
   logic                              sample;
   logic                              finish;

   assign in_idle  = (state == ice51_pkg::TX_IDLE);
   assign in_start = (state == ice51_pkg::TX_START);
   assign in_send  = (state == ice51_pkg::TX_SEND);
   assign load     = in_idle & i_start; // strobe ignored while busy

   //////////////////////////////////////////////////
   // bit timing

   assign sample = (sample_count == ice51_pkg::BIT_CLOCKS);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)                sample_count <= '0;
      else if (in_idle | sample)  sample_count <= '0;
      else                        sample_count <= sample_count + 1'b1;
   end

   assign bit_count_inc = bit_count + 1'b1;
   assign finish        = sample & (bit_count_inc == ice51_pkg::TX_FINAL_COUNT); // end of stop

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)      bit_count <= '0;
      else if (finish)  bit_count <= '0;
      else if (sample)  bit_count <= bit_count_inc;
   end

   //////////////////////////////////////////////////
   // state machine

   assign state_next = load                ? ice51_pkg::TX_START :
                       (in_start & sample) ? ice51_pkg::TX_SEND  :
                       (in_send & finish)  ? ice51_pkg::TX_IDLE  :
                                             state;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= ice51_pkg::TX_IDLE;
      else         state <= state_next;
   end

   //////////////////////////////////////////////////
   // shift register and line

   // MSB first with ones shifted in so the stop bit comes for free
   always_ff @(posedge i_clk) begin
      if (load)                  shift <= i_data;
      else if (in_send & sample) shift <= {shift[6:0], 1'b1};
   end

   assign o_tx   = in_idle  ? 1'b1 :
                   in_start ? 1'b0 :
                              shift[7];
   assign o_busy = ~in_idle;

   //////////////////////////////////////////////////
   // checks

   a_no_start_busy: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      i_start |-> !o_busy
   ) else $error("tx start strobe while busy");

   a_bit_count_range: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      bit_count <= ice51_pkg::TX_FINAL_COUNT
   ) else $error("tx bit count %0d out of range", bit_count);

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
`default_nettype none

module uart_rx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_rx,
   output logic             o_done,
   output ice51_pkg::byte_t o_data
);

   logic                              rx_sync;
   ice51_pkg::rx_state_t              state;
   ice51_pkg::rx_state_t              state_next;
   logic [ice51_pkg::SAMPLE_W-1:0]    count;
   logic [ice51_pkg::SAMPLE_W-1:0]    count_next;
   ice51_pkg::byte_t                  shift;
   ice51_pkg::byte_t                  shift_next;
   logic                              start;
   logic                              full_sample;
   logic                              half_sample;
   logic                              in_start;
   logic                              in_data;

   //////////////////////////////////////////////////
   // line resync

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 1'b1; // idle line is high
      else         rx_sync <= i_rx;
   end

   //////////////////////////////////////////////////
   // state machine

   assign in_start    = (state == ice51_pkg::RX_START);
   assign in_data     = (state == ice51_pkg::RX_DATA);
   assign start       = (state == ice51_pkg::RX_IDLE) & ~rx_sync; // falling start edge
   assign full_sample = (count == ice51_pkg::BIT_CLOCKS);
   assign half_sample = (count == ice51_pkg::HALF_BIT);
   assign o_done      = (state == ice51_pkg::RX_STOP) & full_sample;

   // marker in bit 0 means this sample is the last data bit
   assign state_next = start                                ? ice51_pkg::RX_START :
                       (in_start & half_sample)             ? ice51_pkg::RX_DATA  :
                       (in_data & full_sample & shift[0])   ? ice51_pkg::RX_STOP  :
                       o_done                               ? ice51_pkg::RX_IDLE  :
                                                              state;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= ice51_pkg::RX_IDLE;
      else         state <= state_next;
   end

   //////////////////////////////////////////////////
   // sample counter cleared at every transition point

   assign count_next = (start | o_done | (in_start & half_sample) |
                        (in_data & full_sample)) ? '0 : count + 1'b1;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) count <= '0;
      else         count <= count_next;
   end

   //////////////////////////////////////////////////
   // shift register with LSB arriving first

   assign shift_next = start                   ? ice51_pkg::RX_MARKER  :
                       (in_data & full_sample) ? {rx_sync, shift[7:1]} :
                                                 shift;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) shift <= ice51_pkg::RX_MARKER;
      else         shift <= shift_next;
   end

   assign o_data = shift;

   //////////////////////////////////////////////////
   // checks

   a_data_from_start: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      $rose(state == ice51_pkg::RX_DATA) |-> $past(state) == ice51_pkg::RX_START
   ) else $error("rx entered data phase from a state other than start");

   a_done_one_cycle: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_done |=> !o_done
   ) else $error("rx done held longer than one cycle");

endmodule

`default_nettype wire

//--- common/ice51_pkg.sv
`default_nettype none

package ice51_pkg;

   //////////////////////////////////////////////////
   // bit timing

   localparam int BIT_CLOCKS = 104;             // sample counter terminal value
   localparam int HALF_BIT   = BIT_CLOCKS >> 1; // start edge to bit center
   localparam int SAMPLE_W   = $clog2(BIT_CLOCKS);

   //////////////////////////////////////////////////
   // data and code memory

   typedef logic [7:0] byte_t;

   localparam int CODE_BYTES  = 512; // bytes before load done
   localparam int CODE_ADDR_W = 10;

   //////////////////////////////////////////////////
   // receiver

   typedef enum logic [1:0] {
      RX_IDLE  = 2'b00,
      RX_START = 2'b01,
      RX_DATA  = 2'b11,
      RX_STOP  = 2'b10
   } rx_state_t;

   localparam byte_t RX_MARKER = 8'h80; // shifts down to bit 0 after 7 bits

   //////////////////////////////////////////////////
   // transmitter

   typedef enum logic [1:0] {
      TX_IDLE  = 2'b00,
      TX_START = 2'b01,
      TX_SEND  = 2'b10
   } tx_state_t;

   localparam int TX_FINAL_COUNT = 10; // start + 8 data + stop

endpackage

`default_nettype wire
